/* icache_geom_pkg.sv */
package icache_geom_pkg;

  // 8 KB direct mapped, 128 lines of 64 bytes
  // fetch address = {tag, index, offset}
  localparam int TAG_W          = 19;
  localparam int INDEX_W        = 7;
  localparam int OFFSET_W       = 6;

  // 32-bit words per line
  localparam int WORDS_PER_LINE = 16;

  // full fetch or memory address
  typedef logic [31:0] addr_t;

  // one instruction word
  typedef logic [31:0] word_t;

  // address fields
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [OFFSET_W-1:0] offset_t;

  // word number inside a line, offset bits [5:2]
  typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_sel_t;

endpackage

/* icache_mem_pkg.sv */
package icache_mem_pkg;

  // burst length field, beats minus one
  typedef logic [7:0] beat_len_t;

  // full line refill is 16 beats
  localparam beat_len_t REFILL_LEN   = 8'd15;

  // uncached read is a single beat
  localparam beat_len_t UNCACHED_LEN = 8'd0;

  // counts refill beats 0..15
  typedef logic [3:0] beat_cnt_t;

  // controller states
  typedef enum logic [2:0] {
    ST_RESET,
    ST_IDLE,
    ST_LOOKUP,
    ST_REFILL,
    ST_UNCACHED
  } ctrl_state_t;

endpackage

/* icache_tag_store.sv */
`timescale 1ns/1ns

module icache_tag_store
  import icache_geom_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  tag_t   tag_i,
  input  index_t index_i,
  input  logic   we_i,
  output logic   hit_o
);

  localparam int LINES = 1 << INDEX_W;

  // one tag and one valid bit per line
  tag_t             tags [LINES];
  logic [LINES-1:0] valid_q;

  logic             tag_match;

  // combinational compare against the addressed line
  assign tag_match = tags[index_i] == tag_i;
  assign hit_o     = valid_q[index_i] && tag_match;

  // valid bits are control state
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (we_i) begin
      valid_q[index_i] <= 1'b1;
    end
  end

  // tag array
  always_ff @(posedge clk) begin
    if (we_i) begin
      tags[index_i] <= tag_i;
    end
  end

endmodule

/* icache_data_store.sv */
`timescale 1ns/1ns

module icache_data_store
  import icache_geom_pkg::*;
  import icache_mem_pkg::*;
(
  input  logic      clk,
  // refill write port
  input  logic      we_i,
  input  index_t    wr_index_i,
  input  beat_cnt_t wr_beat_i,
  input  word_t     wdata_i,
  // fetch read port
  input  index_t    rd_index_i,
  input  word_sel_t rd_sel_i,
  output word_t     rdata_o
);

  localparam int DEPTH = WORDS_PER_LINE << INDEX_W;

  // flat word array, address = {line, word}
  word_t mem [DEPTH];

  logic [$clog2(DEPTH)-1:0] wr_addr;
  logic [$clog2(DEPTH)-1:0] rd_addr;
  word_t                    rdata_q;

  // beat k of a refill is word k of the line
  assign wr_addr = {wr_index_i, wr_beat_i};
  assign rd_addr = {rd_index_i, rd_sel_i};

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[wr_addr] <= wdata_i;
    end
  end

  // registered read, data one cycle after the address
  always_ff @(posedge clk) begin
    rdata_q <= mem[rd_addr];
  end

  assign rdata_o = rdata_q;

endmodule

/* icache_ctrl.sv */
`timescale 1ns/1ns

module icache_ctrl
  import icache_geom_pkg::*;
  import icache_mem_pkg::*;
#(
  parameter addr_t UNCACHED_BASE = 32'h1000_0000,
  parameter addr_t UNCACHED_MASK = 32'hf000_0000
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      fetch_valid_i,
  input  addr_t     fetch_addr_i,
  input  logic      hit_i,
  input  word_t     rd_word_i,
  input  logic      mem_rvalid_i,
  input  word_t     mem_rdata_i,
  output logic      fetch_rvalid_o,
  output word_t     fetch_rdata_o,
  output tag_t      tag_o,
  output index_t    index_o,
  output logic      tag_we_o,
  output index_t    rd_index_o,
  output word_sel_t rd_sel_o,
  output logic      fill_we_o,
  output beat_cnt_t fill_beat_o,
  output logic      mem_req_o,
  output addr_t     mem_addr_o,
  output beat_len_t mem_len_o
);

  ctrl_state_t state_q;

  // fetch address captured on acceptance
  tag_t      tag_q;
  index_t    index_q;
  offset_t   offset_q;

  // memory request registers
  logic      mem_req_q;
  addr_t     mem_addr_q;
  beat_len_t mem_len_q;
  beat_cnt_t beat_q;

  logic      tag_we_q;
  word_t     unc_word_q;
  logic      unc_done_q;

  logic      accept;
  logic      beat;
  logic      in_region;
  logic      lookup_hit;
  addr_t     addr_q;

  assign addr_q = {tag_q, index_q, offset_q};

  // new request only when idle and no data strobe pending
  assign accept = (state_q == ST_IDLE) && fetch_valid_i && !fetch_rvalid_o;

  // one beat per edge with req and rvalid both high
  assign beat = mem_req_q && mem_rvalid_i;

  // uncached region check on the captured address
  assign in_region = (addr_q & UNCACHED_MASK) == UNCACHED_BASE;

  assign lookup_hit = (state_q == ST_LOOKUP) && hit_i && !in_region;

  // hit data in the lookup cycle, uncached data the cycle after its beat
  assign fetch_rvalid_o = lookup_hit || unc_done_q;
  assign fetch_rdata_o  = unc_done_q ? unc_word_q : rd_word_i;

  assign tag_o    = tag_q;
  assign index_o  = index_q;
  assign tag_we_o = tag_we_q;

  // read address comes from the bus while idle so the word is ready in lookup
  always_comb begin
    if (state_q == ST_IDLE) begin
      rd_index_o = fetch_addr_i[OFFSET_W +: INDEX_W];
      rd_sel_o   = fetch_addr_i[2 +: $bits(word_sel_t)];
    end else begin
      rd_index_o = index_q;
      rd_sel_o   = offset_q[2 +: $bits(word_sel_t)];
    end
  end

  assign fill_we_o   = beat && (state_q == ST_REFILL);
  assign fill_beat_o = beat_q;

  assign mem_req_o  = mem_req_q;
  assign mem_addr_o = mem_addr_q;
  assign mem_len_o  = mem_len_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= ST_RESET;
      mem_req_q  <= 1'b0;
      mem_addr_q <= '0;
      mem_len_q  <= '0;
      beat_q     <= '0;
      tag_we_q   <= 1'b0;
      unc_done_q <= 1'b0;
    end else begin
      // single cycle strobes
      tag_we_q   <= 1'b0;
      unc_done_q <= 1'b0;
      case (state_q)
        ST_RESET: begin
          state_q <= ST_IDLE;
        end
        ST_IDLE: begin
          if (accept) begin
            state_q <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          if (in_region) begin
            // exact word, single beat
            state_q    <= ST_UNCACHED;
            mem_req_q  <= 1'b1;
            mem_addr_q <= addr_q;
            mem_len_q  <= UNCACHED_LEN;
          end else if (hit_i) begin
            state_q <= ST_IDLE;
          end else begin
            // line aligned burst of the whole line
            state_q    <= ST_REFILL;
            mem_req_q  <= 1'b1;
            mem_addr_q <= {tag_q, index_q, {OFFSET_W{1'b0}}};
            mem_len_q  <= REFILL_LEN;
            beat_q     <= '0;
          end
        end
        ST_REFILL: begin
          if (beat) begin
            if (beat_q == beat_cnt_t'(REFILL_LEN)) begin
              // last beat, tag goes valid next edge
              state_q   <= ST_IDLE;
              mem_req_q <= 1'b0;
              tag_we_q  <= 1'b1;
            end else begin
              beat_q <= beat_q + beat_cnt_t'(1);
            end
          end
        end
        ST_UNCACHED: begin
          if (beat) begin
            state_q    <= ST_IDLE;
            mem_req_q  <= 1'b0;
            unc_done_q <= 1'b1;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // payload regs
  always_ff @(posedge clk) begin
    if (accept) begin
      {tag_q, index_q, offset_q} <= fetch_addr_i;
    end
    if (beat && (state_q == ST_UNCACHED)) begin
      unc_word_q <= mem_rdata_i;
    end
  end

endmodule

/* icache_top.sv */
`timescale 1ns/1ns

module icache_top
  import icache_geom_pkg::*;
  import icache_mem_pkg::*;
#(
  parameter addr_t UNCACHED_BASE = 32'h1000_0000,
  parameter addr_t UNCACHED_MASK = 32'hf000_0000
) (
  input  logic      clk,
  input  logic      rst,
  // fetch side
  input  logic      fetch_valid_i,
  input  addr_t     fetch_addr_i,
  output logic      fetch_rvalid_o,
  output word_t     fetch_rdata_o,
  // memory side
  output logic      mem_req_o,
  output addr_t     mem_addr_o,
  output beat_len_t mem_len_o,
  input  logic      mem_rvalid_i,
  input  word_t     mem_rdata_i
);

  // controller <-> tag store
  logic      hit;
  tag_t      tag;
  index_t    index;
  logic      tag_we;

  // controller <-> data store
  word_t     rd_word;
  index_t    rd_index;
  word_sel_t rd_sel;
  logic      fill_we;
  beat_cnt_t fill_beat;

  icache_ctrl #(
    .UNCACHED_BASE (UNCACHED_BASE),
    .UNCACHED_MASK (UNCACHED_MASK)
  ) u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_addr_i   (fetch_addr_i),
    .hit_i          (hit),
    .rd_word_i      (rd_word),
    .mem_rvalid_i   (mem_rvalid_i),
    .mem_rdata_i    (mem_rdata_i),
    .fetch_rvalid_o (fetch_rvalid_o),
    .fetch_rdata_o  (fetch_rdata_o),
    .tag_o          (tag),
    .index_o        (index),
    .tag_we_o       (tag_we),
    .rd_index_o     (rd_index),
    .rd_sel_o       (rd_sel),
    .fill_we_o      (fill_we),
    .fill_beat_o    (fill_beat),
    .mem_req_o      (mem_req_o),
    .mem_addr_o     (mem_addr_o),
    .mem_len_o      (mem_len_o)
  );

  icache_tag_store u_tag_store (
    .clk     (clk),
    .rst     (rst),
    .tag_i   (tag),
    .index_i (index),
    .we_i    (tag_we),
    .hit_o   (hit)
  );

  // refill beats go straight from the memory bus into the array
  icache_data_store u_data_store (
    .clk        (clk),
    .we_i       (fill_we),
    .wr_index_i (index),
    .wr_beat_i  (fill_beat),
    .wdata_i    (mem_rdata_i),
    .rd_index_i (rd_index),
    .rd_sel_i   (rd_sel),
    .rdata_o    (rd_word)
  );

endmodule

/* icache_assertions.sv */
`timescale 1ns/1ns

module icache_assertions
  import icache_geom_pkg::*;
  import icache_mem_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      fetch_rvalid_i,
  input logic      mem_req_i,
  input addr_t     mem_addr_i,
  input beat_len_t mem_len_i
);

  // failed assertions so far, read by the testbench
  int error_count = 0;

  // burst address and length held until req drops
  property req_stable_p;
    @(posedge clk) disable iff (rst)
      mem_req_i |=> !mem_req_i || ($stable(mem_addr_i) && $stable(mem_len_i));
  endproperty

  // data strobe is a single cycle pulse
  property rvalid_pulse_p;
    @(posedge clk) disable iff (rst)
      fetch_rvalid_i |=> !fetch_rvalid_i;
  endproperty

  // no fetch data while memory is busy
  property rvalid_not_in_burst_p;
    @(posedge clk) disable iff (rst)
      !(fetch_rvalid_i && mem_req_i);
  endproperty

  // only single beat or full line bursts
  property len_legal_p;
    @(posedge clk) disable iff (rst)
      mem_req_i |-> (mem_len_i == 8'd0 || mem_len_i == 8'd15);
  endproperty

  assert property (req_stable_p) else begin
    error_count++;
    $error("memory address or length changed during a burst");
  end

  assert property (rvalid_pulse_p) else begin
    error_count++;
    $error("fetch_rvalid_o high in two consecutive cycles");
  end

  assert property (rvalid_not_in_burst_p) else begin
    error_count++;
    $error("fetch_rvalid_o high while mem_req_o is high");
  end

  assert property (len_legal_p) else begin
    error_count++;
    $error("mem_len_o is neither 0 nor 15 during a request");
  end

endmodule

bind icache_top icache_assertions u_assertions (
  .clk            (clk),
  .rst            (rst),
  .fetch_rvalid_i (fetch_rvalid_o),
  .mem_req_i      (mem_req_o),
  .mem_addr_i     (mem_addr_o),
  .mem_len_i      (mem_len_o)
);

/* icache_tb.sv */
`timescale 1ns/1ns

module icache_tb;

  // uncached window, same values as the DUT defaults
  localparam logic [31:0] UNC_BASE = 32'h1000_0000;
  localparam logic [31:0] UNC_MASK = 32'hf000_0000;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int RANDOM_FETCHES = 300;

  // fetch outcome codes
  localparam int KIND_HIT  = 0;
  localparam int KIND_MISS = 1;
  localparam int KIND_UNC  = 2;

  logic        clk;
  logic        rst;
  logic        fetch_valid;
  logic [31:0] fetch_addr;
  logic        fetch_rvalid;
  logic [31:0] fetch_rdata;
  logic        mem_req;
  logic [31:0] mem_addr;
  logic [7:0]  mem_len;
  logic        mem_rvalid;
  logic [31:0] mem_rdata;

  logic [31:0] lfsr_q;

  // memory responder state
  logic        resp_active;
  logic [31:0] resp_base;
  int          resp_len;
  int          resp_beat;
  int          resp_gap;
  int          req_count;
  logic [31:0] last_req_addr;
  logic [7:0]  last_req_len;

  // reference copy of valid bits and tags
  logic        model_valid [128];
  logic [18:0] model_tag [128];

  icache_top #(
    .UNCACHED_BASE (UNC_BASE),
    .UNCACHED_MASK (UNC_MASK)
  ) DUT (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid_i  (fetch_valid),
    .fetch_addr_i   (fetch_addr),
    .fetch_rvalid_o (fetch_rvalid),
    .fetch_rdata_o  (fetch_rdata),
    .mem_req_o      (mem_req),
    .mem_addr_o     (mem_addr),
    .mem_len_o      (mem_len),
    .mem_rvalid_i   (mem_rvalid),
    .mem_rdata_i    (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1, one shift per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  // memory content rule
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return ~addr ^ 32'h5a5a_0000;
  endfunction

  task automatic stop_on_error();
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("error %s expected 0x%08h actual 0x%08h", name, expected, actual);
      stop_on_error();
    end
  endtask

  // one step of the memory model, called at each falling edge
  task automatic serve_memory();
    if (!mem_req) begin
      resp_active = 1'b0;
      mem_rvalid  = 1'b0;
    end else begin
      if (!resp_active) begin
        // new burst, latch what the cache asked for
        resp_active   = 1'b1;
        resp_base     = mem_addr;
        resp_len      = mem_len;
        resp_beat     = 0;
        resp_gap      = rand_bits(2);
        req_count++;
        last_req_addr = mem_addr;
        last_req_len  = mem_len;
      end
      if (resp_beat > resp_len) begin
        mem_rvalid = 1'b0;
      end else if (resp_gap > 0) begin
        resp_gap--;
        mem_rvalid = 1'b0;
      end else begin
        mem_rvalid = 1'b1;
        mem_rdata  = mem_word(resp_base + 32'(4 * resp_beat));
        resp_beat++;
        resp_gap   = rand_bits(2);
      end
    end
  endtask

  // advance to the next falling edge, outputs are settled there
  task automatic step_cycle();
    @(negedge clk);
    if (DUT.u_assertions.error_count != 0) begin
      $display("a protocol assertion on the DUT failed");
      stop_on_error();
    end
    serve_memory();
  endtask

  task automatic check_quiet(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      step_cycle();
      check_value("reset fetch_rvalid", 0, fetch_rvalid);
      check_value("reset mem_req", 0, mem_req);
    end
  endtask

  // one fetch, predicted from the model and checked on the strobe
  task automatic do_fetch(input string name, input logic [31:0] addr);
    logic [6:0]  idx;
    logic [18:0] tag;
    logic [31:0] exp_data;
    int          kind;
    int          cycles;
    int          reqs_before;
    idx = addr[12:6];
    tag = addr[31:13];
    if ((addr & UNC_MASK) == UNC_BASE) begin
      kind = KIND_UNC;
    end else if (model_valid[idx] && model_tag[idx] == tag) begin
      kind = KIND_HIT;
    end else begin
      kind = KIND_MISS;
    end
    exp_data = mem_word({addr[31:2], 2'b00});
    step_cycle();
    reqs_before = req_count;
    fetch_valid = 1'b1;
    fetch_addr  = addr;
    cycles = 0;
    do begin
      if (cycles == TIMEOUT_CYCLES) begin
        $display("no fetch response for %s within %0d cycles", name, TIMEOUT_CYCLES);
        stop_on_error();
      end
      step_cycle();
      cycles++;
    end while (!fetch_rvalid);
    // request may drop once the strobe is seen
    fetch_valid = 1'b0;
    check_value({name, " data"}, exp_data, fetch_rdata);
    check_value({name, " memory requests"}, (kind == KIND_HIT) ? 0 : 1,
                req_count - reqs_before);
    case (kind)
      KIND_HIT: begin
        check_value({name, " hit latency"}, 1, cycles);
      end
      KIND_MISS: begin
        check_value({name, " refill address"}, {addr[31:6], 6'b0}, last_req_addr);
        check_value({name, " refill length"}, 15, last_req_len);
        model_valid[idx] = 1'b1;
        model_tag[idx]   = tag;
      end
      default: begin
        check_value({name, " uncached address"}, addr, last_req_addr);
        check_value({name, " uncached length"}, 0, last_req_len);
      end
    endcase
  endtask

  // few tags, all indices, plus the uncached window
  function automatic logic [31:0] random_fetch_addr();
    logic [18:0] tag;
    logic [31:0] a;
    if (rand_bits(3) == 0) begin
      a = UNC_BASE | (rand_bits(12) << 2);
    end else begin
      case (rand_bits(2))
        0:       tag = 19'h00000;
        1:       tag = 19'h00001;
        2:       tag = 19'h20002;
        default: tag = 19'h7c0a3;
      endcase
      a = {tag, 7'(rand_bits(7)), 4'(rand_bits(4)), 2'b00};
    end
    return a;
  endfunction

  initial begin
    int i;
    lfsr_q        = 32'hde0c_99a1;
    rst           = 1'b1;
    fetch_valid   = 1'b0;
    fetch_addr    = '0;
    mem_rvalid    = 1'b0;
    mem_rdata     = '0;
    resp_active   = 1'b0;
    resp_base     = '0;
    resp_len      = 0;
    resp_beat     = 0;
    resp_gap      = 0;
    req_count     = 0;
    last_req_addr = '0;
    last_req_len  = '0;
    for (i = 0; i < 128; i++) begin
      model_valid[i] = 1'b0;
      model_tag[i]   = '0;
    end
    // two rising edges in reset, release on the falling edge after
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // quiet after reset
    check_quiet(6);

    // tag 1 line 1, cold
    do_fetch("cold miss", 32'h0000_2044);
    do_fetch("hit", 32'h0000_2048);

    // same index, other tag, then back
    do_fetch("conflict", 32'h0040_2044);
    do_fetch("conflict return", 32'h0000_2044);

    // uncached goes to memory every time
    do_fetch("uncached", 32'h1000_0124);
    do_fetch("uncached repeat", 32'h1000_0124);

    for (i = 0; i < RANDOM_FETCHES; i++) begin
      do_fetch("random", random_fetch_addr());
    end

    if (DUT.u_assertions.error_count == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("a protocol assertion on the DUT failed");
      stop_on_error();
    end
  end

endmodule

/* build.f */
icache_geom_pkg.sv
icache_mem_pkg.sv
icache_tag_store.sv
icache_data_store.sv
icache_ctrl.sv
icache_top.sv
icache_assertions.sv
icache_tb.sv

/* Bender.yml */
package:
  name: icache

sources:
  - icache_geom_pkg.sv
  - icache_mem_pkg.sv
  - icache_tag_store.sv
  - icache_data_store.sv
  - icache_ctrl.sv
  - icache_top.sv
  - target: test
    files:
      - icache_assertions.sv
      - icache_tb.sv
